// ==== hdl/psg_pkg.sv ====
package psg_pkg;

	// ========================================
	// data and address widths
	// ========================================

	// signed wave sample
	localparam int sample_w = 8;
	// wave memory address, table select on top of table index
	localparam int adr_w = 10;
	localparam int tbl_w = 2;

	// phase accumulator, top 8 bits index the table
	localparam int phase_w = 16;
	localparam int freq_w = 16;

	// unsigned channel volume
	localparam int vol_w = 4;

	// 8 channels of sample times volume fit without overflow
	localparam int mix_w = 16;

	// ========================================
	// host register map
	// ========================================

	localparam int reg_dat_w = 16;

	// field code in the low 2 address bits, channel number above
	localparam logic [1:0] reg_fld_freq = 2'd0;
	localparam logic [1:0] reg_fld_vol = 2'd1;
	localparam logic [1:0] reg_fld_tbl = 2'd2;
	localparam logic [1:0] reg_fld_gate = 2'd3;

endpackage

// ==== hdl/psg_regs.sv ====
module psg_regs
	import psg_pkg::*;
#(
	parameter int n_ch = 8,
	localparam int ch_w = $clog2(n_ch)
) (
	input logic clk,
	input logic rst,
	input logic reg_we,
	input logic [ch_w+1:0] reg_adr,
	input logic [reg_dat_w-1:0] reg_dat,
	output logic [n_ch*freq_w-1:0] freq,
	output logic [n_ch*vol_w-1:0] vol,
	output logic [n_ch*tbl_w-1:0] tbl,
	output logic [n_ch-1:0] gate
);

	// ========================================
	// address decode
	// ========================================

	logic [ch_w-1:0] ch;
	logic [1:0] fld;
	logic wr_ok;

	assign ch = reg_adr[ch_w+1:2];
	assign fld = reg_adr[1:0];

	// channel numbers past the last voice are dropped
	assign wr_ok = reg_we && (int'(ch) < n_ch);

	// ========================================
	// per-channel fields
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			vol <= '0;
			tbl <= '0;
			gate <= '0;
		end else if (wr_ok) begin
			case (fld)
				reg_fld_freq: begin
					freq[ch*freq_w +: freq_w] <= reg_dat[freq_w-1:0];
				end
				reg_fld_vol: begin
					vol[ch*vol_w +: vol_w] <= reg_dat[vol_w-1:0];
				end
				reg_fld_tbl: begin
					tbl[ch*tbl_w +: tbl_w] <= reg_dat[tbl_w-1:0];
				end
				reg_fld_gate: begin
					// only bit 0 is meaningful for the gate
					gate[ch] <= reg_dat[0];
				end
			endcase
		end
	end

endmodule

// ==== hdl/psg_bus_arb.sv ====
module psg_bus_arb
	import psg_pkg::*;
#(
	parameter int n_ch = 8,
	localparam int sel_w = $clog2(n_ch)
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [n_ch-1:0] req,
	input logic [n_ch*adr_w-1:0] adr,
	input logic bus_ack,
	output logic [n_ch-1:0] grant,
	output logic bus_cyc,
	output logic [adr_w-1:0] bus_adr
);

	// ========================================
	// priority pick
	// ========================================

	logic [n_ch-1:0] pick;
	logic [sel_w-1:0] pick_n;
	logic [sel_w-1:0] sel;
	logic held;
	logic done;

	// scan from the top so the lowest requester wins
	always_comb begin
		pick = '0;
		pick_n = '0;
		for (int i = n_ch - 1; i >= 0; i--) begin
			if (req[i]) begin
				pick = '0;
				pick[i] = 1'b1;
				pick_n = sel_w'(i);
			end
		end
	end

	// ========================================
	// system side
	// ========================================

	assign held = |grant;

	// single request toward the system, owner still wants the bus
	assign bus_cyc = held && req[sel];

	// owner's fetch address steered out
	assign bus_adr = adr[sel*adr_w +: adr_w];

	// transfer finished, or nothing running
	assign done = bus_ack || !bus_cyc;

	// ========================================
	// grant register
	// ========================================

	// no requester at all means the last owner keeps the grant
	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
			sel <= '0;
		end else if (ce && done && (|req)) begin
			grant <= pick;
			sel <= pick_n;
		end
	end

endmodule

// ==== hdl/wave_channel.sv ====
module wave_channel
	import psg_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic ce,
	input logic gate,
	input logic [freq_w-1:0] freq,
	input logic [tbl_w-1:0] tbl,
	input logic grant,
	input logic bus_ack,
	input logic [sample_w-1:0] bus_dat,
	output logic req,
	output logic [adr_w-1:0] adr,
	output logic signed [sample_w-1:0] sample
);

	localparam int idx_w = adr_w - tbl_w;

	// ========================================
	// phase and wave address
	// ========================================

	logic [phase_w-1:0] phase;
	logic [adr_w-1:0] cur_adr;
	logic loaded;
	logic xfer;
	logic stale;

	// table select on top, high phase bits index the table
	assign cur_adr = {tbl, phase[phase_w-1 -: idx_w]};

	// this voice's transfer completes at this edge
	assign xfer = ce && grant && req && bus_ack;

	// adr holds the last fetched (or in-flight) address
	assign stale = cur_adr != adr;

	// ========================================
	// fetch control and sample hold
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
			loaded <= 1'b0;
			req <= 1'b0;
			adr <= '0;
			sample <= '0;
		end else if (!gate) begin
			// silent voice, next gate starts from phase 0
			phase <= '0;
			loaded <= 1'b0;
			req <= 1'b0;
			sample <= '0;
		end else begin
			if (ce) begin
				phase <= phase + freq;
			end

			if (xfer) begin
				sample <= bus_dat;
				loaded <= 1'b1;
			end

			// new fetch only while idle or just finishing one
			// adr stays put for the whole transfer
			if (ce && (!req || xfer)) begin
				req <= stale || (!loaded && !xfer);
				adr <= cur_adr;
			end
		end
	end

endmodule

// ==== hdl/psg_mixer.sv ====
module psg_mixer
	import psg_pkg::*;
#(
	parameter int n_ch = 8
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [n_ch*sample_w-1:0] sample,
	input logic [n_ch*vol_w-1:0] vol,
	output logic signed [mix_w-1:0] mix
);

	// ========================================
	// scale and sum
	// ========================================

	logic signed [sample_w+vol_w:0] prod [n_ch];
	logic signed [mix_w-1:0] acc;

	// volume is unsigned, so widen it with a zero before the signed multiply
	always_comb begin
		for (int i = 0; i < n_ch; i++) begin
			prod[i] = $signed(sample[i*sample_w +: sample_w]) *
				$signed({1'b0, vol[i*vol_w +: vol_w]});
		end
	end

	// ungated voices hold a zero sample and drop out here
	always_comb begin
		acc = '0;
		for (int i = 0; i < n_ch; i++) begin
			acc = acc + prod[i];
		end
	end

	// ========================================
	// output register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			mix <= '0;
		end else if (ce) begin
			mix <= acc;
		end
	end

endmodule

// ==== hdl/psg_wave_top.sv ====
module psg_wave_top
	import psg_pkg::*;
#(
	parameter int n_ch = 8,
	localparam int ch_w = $clog2(n_ch)
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic reg_we,
	input logic [ch_w+1:0] reg_adr,
	input logic [reg_dat_w-1:0] reg_dat,
	input logic bus_ack,
	input logic [sample_w-1:0] bus_dat,
	output logic bus_cyc,
	output logic [adr_w-1:0] bus_adr,
	output logic signed [mix_w-1:0] mix
);

	// register file outputs, one slice per channel
	logic [n_ch*freq_w-1:0] freq;
	logic [n_ch*vol_w-1:0] vol;
	logic [n_ch*tbl_w-1:0] tbl;
	logic [n_ch-1:0] gate;

	// channel to arbiter
	logic [n_ch-1:0] req;
	logic [n_ch*adr_w-1:0] adr;
	logic [n_ch-1:0] grant;

	// channel to mixer
	logic [n_ch*sample_w-1:0] sample;

	// ========================================
	// host registers
	// ========================================

	psg_regs #(.n_ch(n_ch)) u_regs (
		.clk(clk),
		.rst(rst),
		.reg_we(reg_we),
		.reg_adr(reg_adr),
		.reg_dat(reg_dat),
		.freq(freq),
		.vol(vol),
		.tbl(tbl),
		.gate(gate)
	);

	// ========================================
	// voices
	// ========================================

	for (genvar g = 0; g < n_ch; g++) begin : g_ch
		wave_channel u_ch (
			.clk(clk),
			.rst(rst),
			.ce(ce),
			.gate(gate[g]),
			.freq(freq[g*freq_w +: freq_w]),
			.tbl(tbl[g*tbl_w +: tbl_w]),
			.grant(grant[g]),
			.bus_ack(bus_ack),
			.bus_dat(bus_dat),
			.req(req[g]),
			.adr(adr[g*adr_w +: adr_w]),
			.sample(sample[g*sample_w +: sample_w])
		);
	end

	// ========================================
	// bus arbiter and mixer
	// ========================================

	psg_bus_arb #(.n_ch(n_ch)) u_arb (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.req(req),
		.adr(adr),
		.bus_ack(bus_ack),
		.grant(grant),
		.bus_cyc(bus_cyc),
		.bus_adr(bus_adr)
	);

	psg_mixer #(.n_ch(n_ch)) u_mix (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.sample(sample),
		.vol(vol),
		.mix(mix)
	);

endmodule

// ==== tests/psg_wave_assert.sv ====
module psg_bus_arb_assert #(
	parameter int n_ch = 8
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [n_ch-1:0] req,
	input logic bus_ack,
	input logic [n_ch-1:0] grant,
	input logic bus_cyc
);
	timeunit 1ns;
	timeprecision 100ps;

	// ========================================
	// arbiter properties
	// ========================================

	// at most one owner
	onehot_grant: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant))
		else $error("grant is not one-hot or zero");

	// back-pressure and clock enable freeze the owner
	grant_hold: assert property (@(posedge clk) disable iff (rst)
		(!ce || (bus_cyc && !bus_ack)) |=> $stable(grant))
		else $error("grant moved while it had to hold");

	// grant - 1 masks every lower-numbered channel
	lowest_wins: assert property (@(posedge clk) disable iff (rst)
		(ce && (bus_ack || !bus_cyc) && (|req)) |=>
		(($past(req) & (grant - 1'b1)) == '0))
		else $error("a lower-numbered channel was passed over");

endmodule

bind psg_bus_arb psg_bus_arb_assert #(.n_ch(n_ch)) u_arb_chk (
	.clk(clk),
	.rst(rst),
	.ce(ce),
	.req(req),
	.bus_ack(bus_ack),
	.grant(grant),
	.bus_cyc(bus_cyc)
);

// ==== tests/psg_wave_tb.sv ====
module psg_wave_tb
	import psg_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_ch = 8;
	localparam int n_rows = 6;

	// kind 0 reset, 1 fixed voices, 2 priority, 3 running voices, 4 ce hold
	typedef struct packed {
		logic [2:0] kind;
		logic [7:0] mask;
		logic [15:0] freq;
		logic [15:0] tbls;
		logic [31:0] vols;
		logic [1:0] ce_mode;
		logic slow;
	} row_t;

	logic clk;
	logic rst;
	logic ce;
	logic reg_we;
	logic [4:0] reg_adr;
	logic [reg_dat_w-1:0] reg_dat;
	logic bus_ack;
	logic [sample_w-1:0] bus_dat;
	logic bus_cyc;
	logic [adr_w-1:0] bus_adr;
	logic signed [mix_w-1:0] mix;

	logic [sample_w-1:0] mem [1024];
	logic [adr_w-1:0] served [$];
	row_t rows [n_rows];
	string names [n_rows];
	int errs;
	int row_errs;
	int ce_mode;
	int ce_ticks;
	int stalls;
	logic slow;
	logic waiting;
	int wait_left;
	logic cyc_prev;
	logic [adr_w-1:0] adr_prev;

	psg_wave_top #(.n_ch(n_ch)) dut0 (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.reg_we(reg_we),
		.reg_adr(reg_adr),
		.reg_dat(reg_dat),
		.bus_ack(bus_ack),
		.bus_dat(bus_dat),
		.bus_cyc(bus_cyc),
		.bus_adr(bus_adr),
		.mix(mix)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ========================================
	// wave memory model and ce generation
	// ========================================

	always @(posedge clk) begin
		#2;
		// a stalled cycle must keep the address on the bus
		if (!rst && bus_cyc && cyc_prev && !bus_ack) begin
			stalls++;
			check_value(bus_adr == adr_prev, "bus_adr moved during a stalled transfer");
		end
		cyc_prev = bus_cyc;
		adr_prev = bus_adr;
		case (ce_mode)
			0: ce = 1'b1;
			1: ce = !ce;
			default: ce = 1'b0;
		endcase
		if (ce) begin
			ce_ticks++;
		end
		if (bus_ack) begin
			bus_ack = 1'b0;
		end else if (rst || !bus_cyc) begin
			waiting = 1'b0;
		end else begin
			if (!waiting) begin
				waiting = 1'b1;
				wait_left = slow ? $urandom_range(10, 6) : $urandom_range(5, 0);
			end
			if (wait_left > 0) begin
				wait_left--;
			end else if (ce) begin
				bus_ack = 1'b1;
				bus_dat = mem[bus_adr];
				served.push_back(bus_adr);
				waiting = 1'b0;
			end
		end
	end

	// ========================================
	// helpers
	// ========================================

	task automatic check_value(input logic cond, input string msg);
		assert (cond) else begin
			$display("ERR %0t: %s", $time, msg);
			errs++;
			row_errs++;
		end
	endtask

	function automatic logic [15:0] ch_freq(row_t r, int c);
		return (r.freq == 0) ? 16'h0 : r.freq + 16'(c * 16'h80);
	endfunction

	// expected weighted sum for voices that hold their table's first entry
	function automatic int expected_mix(row_t r);
		int sum;
		sum = 0;
		for (int c = 0; c < n_ch; c++) begin
			if (r.mask[c]) begin
				sum += $signed(mem[{r.tbls[c*2 +: 2], 8'h00}]) * int'(r.vols[c*4 +: 4]);
			end
		end
		return sum;
	endfunction

	// a voice at freq 0 only ever reads entry 0 of its own table
	function automatic logic at_table_start(row_t r, logic [adr_w-1:0] a);
		logic ok;
		ok = 1'b0;
		for (int c = 0; c < n_ch; c++) begin
			if (r.mask[c] && a == {r.tbls[c*2 +: 2], 8'h00}) begin
				ok = 1'b1;
			end
		end
		return ok;
	endfunction

	task automatic write_reg(input int c, input logic [1:0] fld, input logic [15:0] dat);
		@(posedge clk);
		#1;
		reg_we = 1'b1;
		reg_adr = {3'(c), fld};
		reg_dat = dat;
		@(posedge clk);
		#1;
		reg_we = 1'b0;
	endtask

	task automatic set_gates(input row_t r, input logic on);
		for (int c = 0; c < n_ch; c++) begin
			if (r.mask[c]) begin
				write_reg(c, reg_fld_gate, {15'h0, on});
			end
		end
	endtask

	task automatic wait_served(input int n, input int limit);
		int cnt;
		cnt = 0;
		while (served.size() < n && cnt < limit) begin
			@(posedge clk);
			cnt++;
		end
		if (served.size() < n) begin
			$display("timeout: only %0d of %0d fetches were served", served.size(), n);
			errs++;
			row_errs++;
		end
	endtask

	task automatic wait_mix(input int val, input int limit);
		int cnt;
		cnt = 0;
		while (int'(mix) != val && cnt < limit) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		check_value(int'(mix) == val, $sformatf("mix is %0d, expected %0d", mix, val));
	endtask

	task automatic wait_ticks(input int n, input int limit);
		int cnt;
		cnt = 0;
		while (ce_ticks < n && cnt < limit) begin
			@(posedge clk);
			cnt++;
		end
		if (ce_ticks < n) begin
			$display("timeout: clock enable stopped ticking");
			errs++;
			row_errs++;
		end
	endtask

	// each served address must follow one voice's phase, and never repeat
	task automatic check_running(input row_t r);
		int last [n_ch];
		int c;
		logic hit;
		for (int i = 0; i < n_ch; i++) begin
			last[i] = -1;
		end
		foreach (served[i]) begin
			c = -1;
			for (int j = 0; j < n_ch; j++) begin
				if (r.mask[j] && r.tbls[j*2 +: 2] == served[i][9:8]) begin
					c = j;
				end
			end
			hit = 1'b0;
			for (int k = 0; k <= ce_ticks && c >= 0; k++) begin
				if (((k * int'(ch_freq(r, c))) >> 8) % 256 == int'(served[i][7:0])) begin
					hit = 1'b1;
				end
			end
			check_value(c >= 0 && hit, $sformatf("unexpected address %0h", served[i]));
			if (c >= 0) begin
				check_value(int'(served[i][7:0]) > last[c], "address fetched twice");
				last[c] = served[i][7:0];
			end
		end
	endtask

	task automatic run_row(input row_t r);
		int n;
		int cnt;
		n = $countones(r.mask);
		served.delete();
		slow = r.slow;
		ce_mode = (r.kind == 0) ? int'(r.ce_mode) : 2;
		stalls = 0;
		for (int c = 0; c < n_ch; c++) begin
			if (r.mask[c]) begin
				write_reg(c, reg_fld_tbl, 16'(r.tbls[c*2 +: 2]));
				write_reg(c, reg_fld_vol, 16'(r.vols[c*4 +: 4]));
				write_reg(c, reg_fld_freq, ch_freq(r, c));
			end
		end
		set_gates(r, 1'b1);
		if (r.kind == 0 || r.kind == 4) begin
			// nothing may start while idle or while ce is low
			repeat (30) begin
				@(posedge clk);
				#1;
				check_value(!bus_cyc && mix == 0, "bus or mix active when it must stay idle");
			end
		end
		ce_ticks = 0;
		ce_mode = r.ce_mode;
		if (r.kind == 3) begin
			wait_ticks(30, 200);
			set_gates(r, 1'b0);
			check_running(r);
			check_value(served.size() >= n, "running voices fetched too little");
		end else if (r.kind != 0) begin
			wait_served(n, 60 * n);
			wait_mix(expected_mix(r), 100);
			repeat (20) @(posedge clk);
			check_value(served.size() == n, "a fetch was served more than once");
			foreach (served[i]) begin
				check_value(at_table_start(r, served[i]),
					$sformatf("served address %0h", served[i]));
			end
			if (r.kind == 2 && served.size() == 2) begin
				check_value(served[0] == 10'd256, "channel 2 not served first");
				check_value(served[1] == 10'd768, "channel 5 not served second");
			end
			if (r.slow) begin
				check_value(stalls > 0, "slow memory produced no stall");
			end
		end
		ce_mode = 0;
		set_gates(r, 1'b0);
		wait_mix(0, 100);
		cnt = 0;
		while (bus_cyc && cnt < 100) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		check_value(!bus_cyc, "bus did not go idle");
	endtask

	// ========================================
	// stimulus table and run
	// ========================================

	initial begin
		rst = 1'b1;
		ce = 1'b0;
		reg_we = 1'b0;
		reg_adr = '0;
		reg_dat = '0;
		bus_ack = 1'b0;
		bus_dat = '0;
		errs = 0;
		row_errs = 0;
		ce_mode = 0;
		ce_ticks = 0;
		stalls = 0;
		slow = 1'b0;
		waiting = 1'b0;
		wait_left = 0;
		cyc_prev = 1'b0;
		adr_prev = '0;
		void'($urandom(32'h38b7));
		for (int a = 0; a < 1024; a++) begin
			mem[a] = 8'($urandom);
		end

		//           kind  mask    freq     tbls     vols           ce  slow
		rows[0] = {3'd0, 8'h00, 16'h0000, 16'h0000, 32'h0000_0000, 2'd0, 1'b0};
		rows[1] = {3'd1, 8'h08, 16'h0000, 16'h0080, 32'h0000_9000, 2'd0, 1'b0};
		rows[2] = {3'd2, 8'h24, 16'h0000, 16'h0c10, 32'h00c0_0500, 2'd0, 1'b0};
		rows[3] = {3'd1, 8'h41, 16'h0000, 16'h2000, 32'h0300_000f, 2'd0, 1'b1};
		rows[4] = {3'd3, 8'h92, 16'h0200, 16'hc100, 32'h6008_0040, 2'd1, 1'b0};
		rows[5] = {3'd4, 8'h08, 16'h0000, 16'h0040, 32'h0000_7000, 2'd0, 1'b0};
		names[0] = "reset idle";
		names[1] = "single voice";
		names[2] = "priority";
		names[3] = "back-pressure";
		names[4] = "running voices";
		names[5] = "clock enable";

		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 0; r < n_rows; r++) begin
			row_errs = 0;
			run_row(rows[r]);
			$display("test %0d %s: %s", r, names[r], (row_errs == 0) ? "ok" : "FAILED");
		end

		$display("tests run %0d, failed checks %0d", n_rows, errs);
		if (errs == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== psg_wave_top.f ====
hdl/psg_pkg.sv
hdl/psg_regs.sv
hdl/psg_bus_arb.sv
hdl/wave_channel.sv
hdl/psg_mixer.sv
hdl/psg_wave_top.sv
tests/psg_wave_assert.sv
tests/psg_wave_tb.sv

// ==== Bender.yml ====
package:
  name: psg_wave

sources:
  - files:
      - hdl/psg_pkg.sv
      - hdl/psg_regs.sv
      - hdl/psg_bus_arb.sv
      - hdl/wave_channel.sv
      - hdl/psg_mixer.sv
      - hdl/psg_wave_top.sv
  - target: test
    files:
      - tests/psg_wave_assert.sv
      - tests/psg_wave_tb.sv
